//--- verilog/bru_pkg.sv
package bru_pkg;

    // branch condition opcodes, same encoding as the uop cond field
    typedef enum logic [3:0] {
        NONE = 4'd0,  // not a branch
        JIRL = 4'd3,
        B    = 4'd4,
        BL   = 4'd5,
        BEQ  = 4'd6,
        BNE  = 4'd7,
        BLT  = 4'd8,
        BGE  = 4'd9,
        BLTU = 4'd10,
        BGEU = 4'd11
    } br_op_e;

    // one branch micro-op as it enters execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;   // sign-extended word offset
        logic [31:0] src1;  // forwarded
        logic [31:0] src2;  // forwarded
        br_op_e      op;
    } br_issue_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;  // pc+4 when not taken
    } br_pred_t;

    // registered resolution, also the predictor training packet
    typedef struct packed {
        logic        is_br;
        logic        dir_fail;
        logic        addr_fail;  // set on any mispredict
        logic        taken;
        logic [31:0] pc;
        logic [31:0] target;
        logic [31:0] redirect_pc;
    } br_result_t;

    // true for the nine real branch ops
    function automatic logic is_branch_op(br_op_e op);
        case (op)
            JIRL, B, BL,
            BEQ, BNE,
            BLT, BGE,
            BLTU, BGEU: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    // word offset to byte offset
    function automatic logic [31:0] word_offset(logic [31:0] imm);
        return {imm[29:0], 2'b00};
    endfunction

    // fall-through address
    function automatic logic [31:0] seq_pc(logic [31:0] pc);
        return pc + 32'd4;
    endfunction

endpackage

//--- verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import bru_pkg::*;
#(
    parameter int BHT_ENTRIES = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [31:0] lookup_pc,
    output br_pred_t   pred,
    input  logic       update_valid,
    input  br_result_t update
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    logic [1:0]       cnt [BHT_ENTRIES];
    logic [31:0]      tgt [BHT_ENTRIES];
    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] update_idx;
    logic             train;

    assign lookup_idx = lookup_pc[2 +: IDX_W];
    assign update_idx = update.pc[2 +: IDX_W];
    assign train      = update_valid && update.is_br;

    // lookup sees the table before this cycle's update, no bypass
    always_comb begin
        pred.taken = cnt[lookup_idx][1];
        if (pred.taken) begin
            pred.target = tgt[lookup_idx];
        end else begin
            pred.target = seq_pc(lookup_pc);
        end
    end

    // two-bit saturating counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                cnt[i] <= 2'd1;  // weakly not taken
            end
        end else if (train) begin
            if (update.taken) begin
                if (cnt[update_idx] != 2'd3) begin
                    cnt[update_idx] <= cnt[update_idx] + 2'd1;
                end
            end else begin
                if (cnt[update_idx] != 2'd0) begin
                    cnt[update_idx] <= cnt[update_idx] - 2'd1;
                end
            end
        end
    end

    // targets only move on taken results
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                tgt[i] <= '0;
            end
        end else if (train && update.taken) begin
            tgt[update_idx] <= update.target;
        end
    end

endmodule

//--- verilog/ex_branch.sv
`timescale 1ns/1ps

module ex_branch
    import bru_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue_valid,
    input  br_issue_t  issue,
    input  br_pred_t   pred,
    output logic       result_valid,
    output br_result_t result
);

    logic        is_br;
    logic        src_eq;
    logic        src_lt_u;
    logic        src_lt_s;
    logic        cond;
    logic        fact_taken;
    logic [31:0] base;
    logic [31:0] target;
    logic        dir_fail;
    logic        addr_fail;

    assign is_br    = is_branch_op(issue.op);
    assign src_eq   = (issue.src1 == issue.src2);
    assign src_lt_u = (issue.src1 < issue.src2);
    // signed compare decided by the sign bits first
    assign src_lt_s = (issue.src1[31] && !issue.src2[31]) ? 1'b1 :
                      (!issue.src1[31] && issue.src2[31]) ? 1'b0 : src_lt_u;

    always_comb begin
        case (issue.op)
            JIRL, B, BL: cond = 1'b1;
            BEQ:         cond = src_eq;
            BNE:         cond = !src_eq;
            BLT:         cond = src_lt_s;
            BGE:         cond = !src_lt_s;
            BLTU:        cond = src_lt_u;
            BGEU:        cond = !src_lt_u;
            default:     cond = 1'b0;
        endcase
    end

    assign fact_taken = is_br && cond;
    assign base       = (issue.op == JIRL) ? issue.src1 : issue.pc;  // register-relative jirl
    assign target     = base + word_offset(issue.imm);

    always_comb begin
        if (fact_taken != pred.taken) begin
            dir_fail  = 1'b1;
            addr_fail = 1'b1;
        end else if (fact_taken && pred.target != target) begin
            dir_fail  = 1'b0;
            addr_fail = 1'b1;  // right direction, wrong place
        end else begin
            dir_fail  = 1'b0;
            addr_fail = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result.is_br       <= is_br;
            result.dir_fail    <= dir_fail;
            result.addr_fail   <= addr_fail;
            result.taken       <= fact_taken;
            result.pc          <= issue.pc;
            result.target      <= target;  // kept even when not taken
            result.redirect_pc <= fact_taken ? target : seq_pc(issue.pc);
        end
    end

endmodule

//--- verilog/branch_stats.sv
`timescale 1ns/1ps

module branch_stats
    import bru_pkg::*;
#(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             result_valid,
    input  br_result_t       result,
    output logic [CNT_W-1:0] branch_count,
    output logic [CNT_W-1:0] mispredict_count
);

    logic count_br;
    logic count_miss;

    assign count_br   = result_valid && result.is_br;
    // addr_fail covers both kinds, plus non-branches predicted taken
    assign count_miss = result_valid && result.addr_fail;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            branch_count <= '0;
        end else if (count_br) begin
            branch_count <= branch_count + 1'b1;  // wraps
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mispredict_count <= '0;
        end else if (count_miss) begin
            mispredict_count <= mispredict_count + 1'b1;
        end
    end

endmodule

//--- verilog/branch_unit_top.sv
`timescale 1ns/1ps

module branch_unit_top
    import bru_pkg::*;
#(
    parameter int BHT_ENTRIES = 16,
    parameter int CNT_W       = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue_valid,
    input  br_issue_t        issue,
    output logic             result_valid,
    output br_result_t       result,
    output logic [CNT_W-1:0] branch_count,
    output logic [CNT_W-1:0] mispredict_count
);

    br_pred_t pred;

    branch_predictor #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) branch_predictor_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_pc    (issue.pc),
        .pred         (pred),
        .update_valid (result_valid),  // trained from the registered result
        .update       (result)
    );

    ex_branch ex_branch_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .pred         (pred),
        .result_valid (result_valid),
        .result       (result)
    );

    branch_stats #(
        .CNT_W (CNT_W)
    ) branch_stats_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .result_valid     (result_valid),
        .result           (result),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

endmodule

//--- dv/branch_unit_assert.sv
`timescale 1ns/1ps

module branch_unit_assert
    import bru_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       issue_valid,
    input logic       result_valid,
    input br_result_t result
);

    int unsigned fail_count = 0;  // read by the testbench at the end

    result_low_after_reset: assert property (@(posedge clk) !rst_n |=> !result_valid)
        else begin
            $error("result_valid high in the cycle after reset");
            fail_count++;
        end

    // one cycle latency, no bubbles, no stalls
    valid_follows_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |=> result_valid)
        else begin
            $error("result_valid missing one cycle after issue_valid");
            fail_count++;
        end

    no_spurious_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !issue_valid |=> !result_valid)
        else begin
            $error("result_valid high without an issue in the cycle before");
            fail_count++;
        end

    dir_implies_addr: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && result.dir_fail |-> result.addr_fail)
        else begin
            $error("dir_fail set without addr_fail");
            fail_count++;
        end

    fallthrough_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result.taken |-> result.redirect_pc == result.pc + 32'd4)
        else begin
            $error("not-taken redirect_pc is not pc + 4");
            fail_count++;
        end

endmodule

//--- dv/tb_branch_unit.sv
`timescale 1ns/1ps

module tb_branch_unit
    import bru_pkg::*;
;

    localparam int BHT_ENTRIES   = 16;
    localparam int CNT_W         = 16;
    localparam int IDX_W         = $clog2(BHT_ENTRIES);
    localparam int N_RESET_STEPS = 16;
    localparam int N_COND_PER_OP = 40;
    localparam int N_JIRL        = 200;
    localparam int N_RAND        = 2000;
    localparam int N_DRAIN       = 4;
    localparam int TOTAL_CYCLES  = 3 + 1 + N_RESET_STEPS + 10 * N_COND_PER_OP + N_JIRL
                                   + N_RAND + N_DRAIN;
    localparam int TIMEOUT_NS    = TOTAL_CYCLES * 8 * 3 / 2;  // 50 percent margin

    logic             clk;
    logic             rst_n;
    logic             issue_valid;
    br_issue_t        issue;
    logic             result_valid;
    br_result_t       result;
    logic [CNT_W-1:0] branch_count;
    logic [CNT_W-1:0] mispredict_count;

    // reference model state
    logic [1:0]       m_cnt [BHT_ENTRIES];
    logic [31:0]      m_tgt [BHT_ENTRIES];
    logic [CNT_W-1:0] m_br_count;
    logic [CNT_W-1:0] m_miss_count;
    logic             exp_valid;
    br_result_t       exp_res;
    int unsigned      dir_seen;
    int unsigned      addr_only_seen;
    int unsigned      n_checks;
    int unsigned      n_errors;

    branch_unit_top #(
        .BHT_ENTRIES (BHT_ENTRIES),
        .CNT_W       (CNT_W)
    ) branch_unit_top_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .issue_valid      (issue_valid),
        .issue            (issue),
        .result_valid     (result_valid),
        .result           (result),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

    bind branch_unit_top branch_unit_assert branch_unit_assert_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .result_valid (result_valid),
        .result       (result)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [99:0] got, input logic [99:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic br_pred_t predict(input logic [31:0] pc);
        br_pred_t p;
        logic [IDX_W-1:0] idx;
        idx = pc[2 +: IDX_W];
        p.taken = m_cnt[idx][1];
        p.target = p.taken ? m_tgt[idx] : pc + 32'd4;
        return p;
    endfunction

    function automatic br_result_t resolve_branch(input br_issue_t iss, input br_pred_t p);
        br_result_t r;
        logic [31:0] base;
        r.is_br = 1'b1;
        r.taken = 1'b0;
        case (iss.op)
            JIRL, B, BL: r.taken = 1'b1;
            BEQ:     r.taken = (iss.src1 == iss.src2);
            BNE:     r.taken = (iss.src1 != iss.src2);
            BLT:     r.taken = ($signed(iss.src1) < $signed(iss.src2));
            BGE:     r.taken = ($signed(iss.src1) >= $signed(iss.src2));
            BLTU:    r.taken = (iss.src1 < iss.src2);
            BGEU:    r.taken = (iss.src1 >= iss.src2);
            default: r.is_br = 1'b0;  // NONE
        endcase
        base = (iss.op == JIRL) ? iss.src1 : iss.pc;
        r.target = base + iss.imm * 32'd4;
        r.pc = iss.pc;
        r.redirect_pc = r.taken ? r.target : iss.pc + 32'd4;
        r.dir_fail = (r.taken != p.taken);
        r.addr_fail = r.dir_fail || (r.taken && p.target != r.target);
        return r;
    endfunction

    task automatic apply_update(input br_result_t res);
        logic [IDX_W-1:0] idx;
        idx = res.pc[2 +: IDX_W];
        if (res.is_br) begin
            m_br_count = m_br_count + CNT_W'(1);
            if (res.taken) begin
                if (m_cnt[idx] != 2'd3) begin
                    m_cnt[idx] = m_cnt[idx] + 2'd1;
                end
                m_tgt[idx] = res.target;
            end else if (m_cnt[idx] != 2'd0) begin
                m_cnt[idx] = m_cnt[idx] - 2'd1;
            end
        end
        if (res.addr_fail) begin
            m_miss_count = m_miss_count + CNT_W'(1);
        end
    endtask

    // lookup first, then the update of the result ending this cycle
    task automatic model_clock_edge();
        br_result_t r;
        r = resolve_branch(issue, predict(issue.pc));
        if (exp_valid) begin
            apply_update(exp_res);
        end
        if (issue_valid) begin
            exp_res = r;
            if (r.dir_fail) begin
                dir_seen++;
            end
            if (r.addr_fail && !r.dir_fail) begin
                addr_only_seen++;
            end
        end
        exp_valid = issue_valid;
    endtask

    task automatic compare_outputs();
        check("result_valid", 100'(result_valid), 100'(exp_valid));
        if (exp_valid) begin
            check("result.is_br", 100'(result.is_br), 100'(exp_res.is_br));
            check("result.dir_fail", 100'(result.dir_fail), 100'(exp_res.dir_fail));
            check("result.addr_fail", 100'(result.addr_fail), 100'(exp_res.addr_fail));
            check("result.taken", 100'(result.taken), 100'(exp_res.taken));
            check("result.pc", 100'(result.pc), 100'(exp_res.pc));
            check("result.target", 100'(result.target), 100'(exp_res.target));
            check("result.redirect_pc", 100'(result.redirect_pc), 100'(exp_res.redirect_pc));
        end
        check("branch_count", 100'(branch_count), 100'(m_br_count));
        check("mispredict_count", 100'(mispredict_count), 100'(m_miss_count));
    endtask

    // drive on the rising edge, look at the outputs on the falling one
    task automatic issue_cycle(input logic v, input br_issue_t iss);
        @(posedge clk);
        model_clock_edge();
        issue_valid <= v;
        issue       <= iss;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic apply_reset();
        rst_n       <= 1'b0;
        issue_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            m_cnt[i] = 2'd1;
            m_tgt[i] = '0;
        end
        m_br_count   = '0;
        m_miss_count = '0;
        exp_valid    = 1'b0;
    endtask

    function automatic br_op_e pick_op(input int k);
        case (k)
            0:       return NONE;
            1:       return JIRL;
            2:       return B;
            3:       return BL;
            4:       return BEQ;
            5:       return BNE;
            6:       return BLT;
            7:       return BGE;
            8:       return BLTU;
            default: return BGEU;
        endcase
    endfunction

    function automatic logic [31:0] boundary_value();
        case ($urandom_range(0, 5))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h8000_0001;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic br_issue_t rand_issue(input br_op_e op);
        br_issue_t iss;
        iss.pc = 32'h1c00_0000 + 32'd36 * $urandom_range(0, 31);  // 32 pcs on 16 entries
        if ($urandom_range(0, 9) == 0) begin
            iss.imm = $urandom();
        end else begin
            iss.imm = $urandom_range(0, 255) - 32'd128;
        end
        case ($urandom_range(0, 3))
            0: begin
                iss.src1 = $urandom();
                iss.src2 = $urandom();
            end
            1: begin
                iss.src1 = $urandom();
                iss.src2 = iss.src1;
            end
            2: begin
                iss.src1 = boundary_value();
                iss.src2 = boundary_value();
            end
            default: begin
                iss.src1 = $urandom();
                iss.src2 = $urandom();
                iss.src2[31] = ~iss.src1[31];  // signs differ
            end
        endcase
        iss.op = op;
        return iss;
    endfunction

    task automatic report_test(input string name, input int n, input int unsigned err_start);
        $display("test %s finished: %0d cycles, %0d errors", name, n, n_errors - err_start);
    endtask

    initial begin
        br_issue_t   iss;
        int unsigned err_start;
        int unsigned seen_start;
        logic [31:0] jirl_base;

        clk         = 1'b0;
        rst_n       <= 1'b0;
        issue_valid <= 1'b0;
        issue       <= '0;
        n_checks       = 0;
        n_errors       = 0;
        dir_seen       = 0;
        addr_only_seen = 0;
        exp_valid      = 1'b0;
        void'($urandom(43));

        err_start = n_errors;
        apply_reset();
        @(negedge clk);
        check("result_valid", 100'(result_valid), 100'(1'b0));
        check("branch_count", 100'(branch_count), 100'(0));
        check("mispredict_count", 100'(mispredict_count), 100'(0));
        for (int i = 0; i < N_RESET_STEPS; i++) begin
            iss = rand_issue(NONE);  // no training, table stays fresh
            iss.pc = 32'h1c00_0000 + 32'(i) * 32'd4;
            issue_cycle(1'b1, iss);
            check("pred.taken", 100'(branch_unit_top_inst.pred.taken), 100'(1'b0));
            check("pred.target", 100'(branch_unit_top_inst.pred.target), 100'(iss.pc + 32'd4));
        end
        report_test("reset", N_RESET_STEPS, err_start);

        err_start = n_errors;
        for (int k = 0; k < 10; k++) begin
            for (int n = 0; n < N_COND_PER_OP; n++) begin
                issue_cycle(1'b1, rand_issue(pick_op(k)));
            end
        end
        report_test("conditions", 10 * N_COND_PER_OP, err_start);

        err_start  = n_errors;
        seen_start = addr_only_seen;
        jirl_base  = 32'h1c01_0000;
        for (int n = 0; n < N_JIRL; n++) begin
            iss = rand_issue(JIRL);
            iss.pc  = 32'h1c00_0200;
            iss.imm = 32'd8;
            if ($urandom_range(0, 2) == 0) begin
                jirl_base = jirl_base + 32'h40;  // moves the jump target
            end
            iss.src1 = jirl_base;
            issue_cycle(1'b1, iss);
        end
        if (addr_only_seen == seen_start) begin
            $display("JIRL test error: no address-only misprediction was seen");
            n_errors++;
        end
        report_test("jirl_address", N_JIRL, err_start);

        err_start  = n_errors;
        seen_start = dir_seen;
        for (int n = 0; n < N_RAND; n++) begin
            issue_cycle($urandom_range(0, 9) < 8, rand_issue(pick_op($urandom_range(0, 9))));
        end
        if (dir_seen == seen_start) begin
            $display("random test error: no direction misprediction was seen");
            n_errors++;
        end
        report_test("random_training", N_RAND, err_start);

        for (int n = 0; n < N_DRAIN; n++) begin
            issue_cycle(1'b0, '0);
        end

        n_errors = n_errors + branch_unit_top_inst.branch_unit_assert_inst.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
                 branch_unit_top_inst.branch_unit_assert_inst.fail_count);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- vlog.f
verilog/bru_pkg.sv
verilog/branch_predictor.sv
verilog/ex_branch.sv
verilog/branch_stats.sv
verilog/branch_unit_top.sv
dv/branch_unit_assert.sv
dv/tb_branch_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the branch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_branch_unit \
    -f vlog.f \
    -o Vtb_branch_unit

./obj_dir/Vtb_branch_unit +verilator+error+limit+1000 | tee "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"
